// ==== cpuTop.f ====
+incdir+source
source/cpuTypes_pkg.sv
source/busTypes_pkg.sv
source/regFile.sv
source/alu.sv
source/controller.sv
source/datapath.sv
source/instrMem.sv
source/hostRegs.sv
source/cpuTop.sv
testbench/cpuTop_sva.sv
testbench/cpuTop_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the cpuTop testbench with Verilator, the verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module cpuTop_tb -f cpuTop.f \
    && ./obj_dir/VcpuTop_tb; } > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log

// ==== source/alu.sv ====
`timescale 1ns/10ps
`include "core_consts.svh"

module alu import cpuTypes_pkg::*; (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  aluOpE              aluOp,
  input  flagsT              prevFlags,
  output logic [`DATA_W-1:0] result,
  output flagsT              flags
);

  logic               isSub;
  logic               arith;
  logic [`DATA_W-1:0] bEff;
  logic [`DATA_W:0]   sum;

  // One adder for ADD, SUB and CMP, subtract as a + ~b + 1
  assign isSub = (aluOp == opSub) || (aluOp == opCmp);
  assign arith = isSub || (aluOp == opAdd);
  assign bEff  = isSub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, bEff} + (`DATA_W+1)'(isSub);

  always_comb begin
    case (aluOp)
      opAnd:               result = a & b;
      opEor:               result = a ^ b;
      opOrr:               result = a | b;
      opMov:               result = b;
      opSub, opAdd, opCmp: result = sum[`DATA_W-1:0];
      default:             result = '0;
    endcase
  end

  assign flags.n = result[`DATA_W-1];
  assign flags.z = (result == '0);
  // Carry out is "no borrow" on subtract, logical ops keep C and V
  assign flags.c = arith ? sum[`DATA_W] : prevFlags.c;
  assign flags.v = arith ? (a[`DATA_W-1] == bEff[`DATA_W-1]) &&
                           (result[`DATA_W-1] != a[`DATA_W-1]) : prevFlags.v;

endmodule

// ==== source/busTypes_pkg.sv ====
`include "core_consts.svh"

package busTypes_pkg;

  // Wishbone classic request from the host
  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    logic [`WB_AW-1:0]  adr;
    logic [`DATA_W-1:0] dat;
  } wbReqT;

  typedef struct packed {
    logic               ack;
    logic [`DATA_W-1:0] dat;
  } wbRspT;

  typedef struct packed {
    logic                start;
    logic                imemWe;
    logic [`IMEM_AW-1:0] imemAdr;
    logic [`DATA_W-1:0]  imemDat;
    logic [`REG_AW-1:0]  dbgReg;
  } hostCmdT;

  typedef struct packed {
    logic                running;
    logic                halted;
    cpuTypes_pkg::flagsT flags;
  } coreStatusT;

endpackage

// ==== source/controller.sv ====
`timescale 1ns/10ps

module controller import cpuTypes_pkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       start,
  input  instrT      instrD,
  input  flagsT      flagsE,
  input  logic       match1EM, match1EW, match2EM, match2EW,
  output ctrlT       ctrlE,
  output ctrlT       ctrlM,
  output ctrlT       ctrlW,
  output logic [1:0] fwdA,
  output logic [1:0] fwdB,
  output logic       stallF,
  output logic       flushD,
  output logic       running,
  output logic       halted
);

  typedef enum logic [1:0] {idle, run, drain} runStateE;

  runStateE state;
  ctrlT     ctrlD, ctrlERaw;
  logic     validD, condPass, haltE;

  // 2'b10 takes the M result, 2'b01 the W result, M is younger and wins
  function automatic logic [1:0] fwdSel(input logic matchM, input logic wrM,
                                        input logic matchW, input logic wrW);
    if (matchM && wrM) return 2'b10;
    if (matchW && wrW) return 2'b01;
    return 2'b00;
  endfunction

  always_comb begin
    ctrlD = '0;
    if (validD) begin
      ctrlD.valid    = 1'b1;
      ctrlD.halt     = (instrD.cond == condNv);
      ctrlD.useImm   = instrD.imm;
      ctrlD.aluOp    = instrD.opcode;
      ctrlD.cond     = instrD.cond;
      ctrlD.regWrite = (instrD.opcode != opCmp) && !ctrlD.halt;
      ctrlD.setFlags = (instrD.setFlags || instrD.opcode == opCmp) && !ctrlD.halt;
    end
  end

  // Condition check in E against the current flags
  always_comb begin
    case (ctrlERaw.cond)
      condEq:  condPass = flagsE.z;
      condNe:  condPass = !flagsE.z;
      default: condPass = 1'b1;
    endcase
    ctrlE = ctrlERaw;
    if (!condPass) begin
      ctrlE.valid    = 1'b0;
      ctrlE.regWrite = 1'b0;
      ctrlE.setFlags = 1'b0;
    end
  end

  assign fwdA    = fwdSel(match1EM, ctrlM.regWrite, match1EW, ctrlW.regWrite);
  assign fwdB    = fwdSel(match2EM, ctrlM.regWrite, match2EW, ctrlW.regWrite);
  assign haltE   = ctrlE.valid && ctrlE.halt;
  assign stallF  = (state != run) || haltE;
  assign flushD  = haltE;
  assign running = (state != idle);

  always_ff @(posedge clk) begin
    if (!rstN || start) begin
      validD   <= 1'b0;
      ctrlERaw <= '0;
      ctrlM    <= '0;
      ctrlW    <= '0;
    end else begin
      validD   <= !stallF;
      ctrlERaw <= flushD ? '0 : ctrlD;
      ctrlM    <= ctrlE;
      ctrlW    <= ctrlM;
    end
  end

  // Run sequence, drain waits for HALT to leave W
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state  <= idle;
      halted <= 1'b0;
    end else if (start) begin
      state  <= run;
      halted <= 1'b0;
    end else begin
      case (state)
        run: begin
          if (haltE) state <= drain;
        end
        drain: begin
          if (ctrlW.valid && ctrlW.halt) begin
            state  <= idle;
            halted <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// ==== source/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register file widths
`define DATA_W      32
`define REG_AW      4
`define NUM_REGS    16

// Instruction store, word addressed
`define IMEM_AW     6
`define IMEM_DEPTH  64

// Host byte address map
`define WB_AW       12
`define CTRL_ADR    12'h100
`define STATUS_ADR  12'h104
`define FLAGS_ADR   12'h108
`define REGS_BASE   12'h140

`endif

// ==== source/cpuTop.sv ====
`timescale 1ns/10ps
`include "core_consts.svh"

module cpuTop import cpuTypes_pkg::*, busTypes_pkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  wbReqT wbReq,
  output wbRspT wbRsp
);

  hostCmdT             cmd;
  coreStatusT          status;
  instrT               instrD;
  flagsT               flagsE, aluFlags;
  ctrlT                ctrlE, ctrlW;
  logic [1:0]          fwdA, fwdB;
  logic                stallF, flushD, running, halted;
  logic                match1EM, match1EW, match2EM, match2EW;
  logic [`IMEM_AW-1:0] pcF;
  logic [`DATA_W-1:0]  fetchInstr, aluA, aluB, aluResult, regRd1, regRd2, regWd, dbgData;
  logic [`REG_AW-1:0]  regRa1, regRa2, regWa;

  assign status = '{running: running, halted: halted, flags: flagsE};

  hostRegs hostRegs_inst (.clk, .rstN, .wbReq, .wbRsp, .cmd, .status, .dbgData);

  instrMem #(.depth(`IMEM_DEPTH)) instrMem_inst (.clk, .we(cmd.imemWe), .wadr(cmd.imemAdr),
    .wdat(cmd.imemDat), .radr(pcF), .rdat(fetchInstr));

  controller controller_inst (.clk, .rstN, .start(cmd.start), .instrD, .flagsE, .match1EM,
    .match1EW, .match2EM, .match2EW, .ctrlE, .ctrlM(), .ctrlW, .fwdA, .fwdB, .stallF,
    .flushD, .running, .halted);

  datapath datapath_inst (.clk, .rstN, .start(cmd.start), .stallF, .flushD, .ctrlE, .ctrlW,
    .fwdA, .fwdB, .fetchInstr, .pcF, .instrD, .aluA, .aluB, .aluResult, .aluFlags, .flagsE,
    .regRa1, .regRa2, .regRd1, .regRd2, .regWa, .regWd, .match1EM, .match1EW, .match2EM,
    .match2EW);

  regFile regFile_inst (.clk, .we(ctrlW.regWrite), .wa(regWa), .wd(regWd), .ra1(regRa1),
    .ra2(regRa2), .rd1(regRd1), .rd2(regRd2), .dbgReg(cmd.dbgReg), .dbgData);

  alu alu_inst (.a(aluA), .b(aluB), .aluOp(ctrlE.aluOp), .prevFlags(flagsE),
    .result(aluResult), .flags(aluFlags));

endmodule

// ==== source/cpuTypes_pkg.sv ====
`include "core_consts.svh"

package cpuTypes_pkg;

  // ARM condition field, NV is used as HALT
  typedef enum logic [3:0] {
    condEq = 4'h0,
    condNe = 4'h1,
    condAl = 4'hE,
    condNv = 4'hF
  } condE;

  // Data-processing opcodes with their ARM encodings
  typedef enum logic [3:0] {
    opAnd = 4'h0,
    opEor = 4'h1,
    opSub = 4'h2,
    opAdd = 4'h4,
    opCmp = 4'hA,
    opOrr = 4'hC,
    opMov = 4'hD
  } aluOpE;

  typedef struct packed {
    condE        cond;
    logic [1:0]  rsvd;
    logic        imm;
    aluOpE       opcode;
    logic        setFlags;
    logic [`REG_AW-1:0] rn;
    logic [`REG_AW-1:0] rd;
    // imm8 in [7:0] or rm in [3:0]
    logic [11:0] op2;
  } instrT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    logic  valid;
    logic  regWrite;
    logic  useImm;
    logic  setFlags;
    aluOpE aluOp;
    condE  cond;
    logic  halt;
  } ctrlT;

endpackage

// ==== source/datapath.sv ====
`timescale 1ns/10ps
`include "core_consts.svh"

module datapath import cpuTypes_pkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic                start,
  input  logic                stallF,
  input  logic                flushD,
  input  ctrlT                ctrlE,
  input  ctrlT                ctrlW,
  input  logic [1:0]          fwdA,
  input  logic [1:0]          fwdB,
  input  logic [`DATA_W-1:0]  fetchInstr,
  output logic [`IMEM_AW-1:0] pcF,
  output instrT               instrD,
  output logic [`DATA_W-1:0]  aluA,
  output logic [`DATA_W-1:0]  aluB,
  input  logic [`DATA_W-1:0]  aluResult,
  input  flagsT               aluFlags,
  output flagsT               flagsE,
  output logic [`REG_AW-1:0]  regRa1,
  output logic [`REG_AW-1:0]  regRa2,
  input  logic [`DATA_W-1:0]  regRd1,
  input  logic [`DATA_W-1:0]  regRd2,
  output logic [`REG_AW-1:0]  regWa,
  output logic [`DATA_W-1:0]  regWd,
  output logic                match1EM, match1EW, match2EM, match2EW
);

  logic [`DATA_W-1:0] immD, rd1E, rd2E, immE, srcBE, resultM, resultW;
  logic [`REG_AW-1:0] ra1E, ra2E, waE, waM, waW;

  // Fetch, PC counts words
  always_ff @(posedge clk) begin
    if (!rstN || start) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcF + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (flushD) begin
      instrD <= '0;
    end else if (!stallF) begin
      instrD <= instrT'(fetchInstr);
    end
  end

  // Decode
  assign regRa1 = instrD.rn;
  assign regRa2 = instrD.op2[`REG_AW-1:0];
  assign immD   = {{(`DATA_W-8){1'b0}}, instrD.op2[7:0]};

  // Execute
  always_ff @(posedge clk) begin
    rd1E <= regRd1;
    rd2E <= regRd2;
    immE <= immD;
    ra1E <= regRa1;
    ra2E <= regRa2;
    waE  <= instrD.rd;
  end

  always_comb begin
    case (fwdA)
      2'b10:   aluA = resultM;
      2'b01:   aluA = resultW;
      default: aluA = rd1E;
    endcase
    case (fwdB)
      2'b10:   srcBE = resultM;
      2'b01:   srcBE = resultW;
      default: srcBE = rd2E;
    endcase
  end

  assign aluB = ctrlE.useImm ? immE : srcBE;

  // Flags follow the last flag-setting instruction that passed its condition
  always_ff @(posedge clk) begin
    if (!rstN || start) begin
      flagsE <= '0;
    end else if (ctrlE.setFlags) begin
      flagsE <= aluFlags;
    end
  end

  // Memory and writeback only carry the result
  always_ff @(posedge clk) begin
    resultM <= aluResult;
    waM     <= waE;
    resultW <= resultM;
    waW     <= waM;
  end

  assign regWa = waW;
  // Quiet write bus while W holds a bubble
  assign regWd = ctrlW.regWrite ? resultW : '0;

  // Hazard comparison, gated with regWrite in the controller
  assign match1EM = (waM == ra1E);
  assign match1EW = (waW == ra1E);
  assign match2EM = (waM == ra2E);
  assign match2EW = (waW == ra2E);

endmodule

// ==== source/hostRegs.sv ====
`timescale 1ns/10ps
`include "core_consts.svh"

module hostRegs import busTypes_pkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  wbReqT              wbReq,
  output wbRspT              wbRsp,
  output hostCmdT            cmd,
  input  coreStatusT         status,
  input  logic [`DATA_W-1:0] dbgData
);

  logic                req, wrReq, ackQ, startQ, imemWeQ;
  logic [`DATA_W-1:0]  rdMux, rdDataQ, imemDatQ;
  logic [`IMEM_AW-1:0] imemAdrQ;

  // New access seen while ack is still low
  assign req   = wbReq.cyc && wbReq.stb && !ackQ;
  assign wrReq = req && wbReq.we;

  always_comb begin
    rdMux = '0;
    if (wbReq.adr == `CTRL_ADR) rdMux = {{(`DATA_W-1){1'b0}}, status.running};
    else if (wbReq.adr == `STATUS_ADR) rdMux = {{(`DATA_W-2){1'b0}}, status.halted, status.running};
    else if (wbReq.adr == `FLAGS_ADR) rdMux = {{(`DATA_W-4){1'b0}}, status.flags};
    else if ((wbReq.adr & 12'hFC0) == `REGS_BASE) rdMux = dbgData;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ackQ    <= 1'b0;
      startQ  <= 1'b0;
      imemWeQ <= 1'b0;
    end else begin
      ackQ    <= req;
      startQ  <= wrReq && (wbReq.adr == `CTRL_ADR) && wbReq.dat[0];
      // Program loads only while the core is stopped
      imemWeQ <= wrReq && (wbReq.adr < `CTRL_ADR) && !status.running;
    end
  end

  always_ff @(posedge clk) begin
    if (req) rdDataQ <= rdMux;
    imemAdrQ <= wbReq.adr[`IMEM_AW+1:2];
    imemDatQ <= wbReq.dat;
  end

  assign wbRsp = '{ack: ackQ, dat: rdDataQ};
  assign cmd   = '{start: startQ, imemWe: imemWeQ, imemAdr: imemAdrQ, imemDat: imemDatQ,
                   dbgReg: wbReq.adr[`REG_AW+1:2]};

endmodule

// ==== source/instrMem.sv ====
`timescale 1ns/10ps
`include "core_consts.svh"

module instrMem #(
  parameter int depth = `IMEM_DEPTH
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] wadr,
  input  logic [`DATA_W-1:0]       wdat,
  input  logic [$clog2(depth)-1:0] radr,
  output logic [`DATA_W-1:0]       rdat
);

  logic [`DATA_W-1:0] mem [depth];

  // Host side write
  always_ff @(posedge clk) begin
    if (we) mem[wadr] <= wdat;
  end

  // Fetch reads in the same cycle
  assign rdat = mem[radr];

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`include "core_consts.svh"

module regFile (
  input  logic               clk,
  input  logic               we,
  input  logic [`REG_AW-1:0] wa,
  input  logic [`DATA_W-1:0] wd,
  input  logic [`REG_AW-1:0] ra1,
  input  logic [`REG_AW-1:0] ra2,
  output logic [`DATA_W-1:0] rd1,
  output logic [`DATA_W-1:0] rd2,
  input  logic [`REG_AW-1:0] dbgReg,
  output logic [`DATA_W-1:0] dbgData
);

  logic [`DATA_W-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  // Write-through, decode sees the value retiring in W this cycle
  assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

  // Host debug read
  assign dbgData = regs[dbgReg];

endmodule

// ==== testbench/cpuTop_sva.sv ====
`timescale 1ns/10ps

module cpuTop_sva import busTypes_pkg::*; (
  input logic       clk,
  input logic       rstN,
  input wbReqT      wbReq,
  input wbRspT      wbRsp,
  input coreStatusT status
);

  // Classic cycle, ack is a single pulse
  ackOnePulse: assert property (@(posedge clk) disable iff (!rstN)
    wbRsp.ack |=> !wbRsp.ack)
    else $error("ack stayed high for more than one cycle");

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
    else $error("ack without a preceding cyc and stb");

  runHaltExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(status.running && status.halted))
    else $error("running and halted both set");

  // First edge out of reset
  ackLowAfterReset: assert property (@(posedge clk) $past(!rstN) && rstN |-> !wbRsp.ack)
    else $error("ack high right after reset");

endmodule

bind hostRegs cpuTop_sva cpuTop_sva_inst (.clk, .rstN, .wbReq, .wbRsp, .status);

// ==== testbench/cpuTop_tb.sv ====
`timescale 1ns/10ps
`include "core_consts.svh"

module cpuTop_tb import busTypes_pkg::*; ();

  // ARM field encodings used to build programs
  localparam logic [3:0] ccEq = 4'h0, ccNe = 4'h1, ccAl = 4'hE, ccNv = 4'hF;
  localparam logic [3:0] opcAnd = 4'h0, opcEor = 4'h1, opcSub = 4'h2, opcAdd = 4'h4;
  localparam logic [3:0] opcCmp = 4'hA, opcOrr = 4'hC, opcMov = 4'hD;
  localparam logic [3:0] opcList [7] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'hA, 4'hC, 4'hD};
  // AL twice so that most random instructions execute
  localparam logic [3:0] condList [4] = '{4'hE, 4'hE, 4'h0, 4'h1};
  localparam logic [31:0] haltWord = 32'hF000_0000;

  logic        clk, rstN;
  wbReqT       wbReq;
  wbRspT       wbRsp;
  int          checks, mismatches, otherErrors;
  logic [31:0] lcgState;
  logic [31:0] prog [$];
  // Reference machine state
  logic [31:0] mRegs [16];
  logic        mKnown [16];
  logic [3:0]  mFlags;

  cpuTop cpuTop_inst (.clk, .rstN, .wbReq, .wbRsp);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] encode(input logic [3:0] cond, input logic imm,
      input logic [3:0] opc, input logic s, input logic [3:0] rn, input logic [3:0] rd,
      input logic [11:0] op2);
    return {cond, 2'b00, imm, opc, s, rn, rd, op2};
  endfunction

  // Upper bits are the useful ones
  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic finishRun();
    $display("Checks: %0d  mismatches: %0d  other errors: %0d",
             checks, mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic abortRun(input string why);
    otherErrors++;
    $display("ERROR: %s", why);
    finishRun();
  endtask

  task automatic checkEqual(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Samples ack on the falling edge, away from the DUT's updates
  task automatic waitAck();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!wbRsp.ack) begin
      if (cnt == 16) abortRun("Wishbone access got no ack within 16 cycles");
      cnt++;
      @(negedge clk);
    end
  endtask

  task automatic wbWrite(input logic [11:0] adr, input logic [31:0] dat);
    @(posedge clk);
    wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    waitAck();
    @(posedge clk);
    wbReq <= '0;
  endtask

  task automatic wbRead(input logic [11:0] adr, output logic [31:0] data);
    @(posedge clk);
    wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
    waitAck();
    data = wbRsp.dat;
    @(posedge clk);
    wbReq <= '0;
  endtask

  task automatic waitHalted();
    logic [31:0] st;
    int          polls;
    polls = 0;
    wbRead(`STATUS_ADR, st);
    while (!st[1]) begin
      if (polls == 100) abortRun("core did not halt within 100 status polls");
      polls++;
      wbRead(`STATUS_ADR, st);
    end
    checkEqual("status after halt", 32'h2, st);
  endtask

  task automatic loadProg();
    for (int i = 0; i < prog.size(); i++) begin
      wbWrite(12'(i * 4), prog[i]);
    end
  endtask

  // Sequential interpreter of the program, flags start cleared
  task automatic runModel();
    logic [31:0] w, a, b, res;
    logic [32:0] wide;
    logic [3:0]  opc;
    logic        pass, isSub, ovf;
    mFlags = 4'h0;
    for (int i = 0; i < prog.size(); i++) begin
      w = prog[i];
      if (w[31:28] == ccNv) break;
      pass = (w[31:28] == ccAl) || (w[31:28] == ccEq && mFlags[2]) ||
             (w[31:28] == ccNe && !mFlags[2]);
      if (pass) begin
        opc   = w[24:21];
        a     = mRegs[w[19:16]];
        b     = w[25] ? {24'h0, w[7:0]} : mRegs[w[3:0]];
        isSub = (opc == opcSub) || (opc == opcCmp);
        wide  = isSub ? {1'b0, a} - {1'b0, b} : {1'b0, a} + {1'b0, b};
        case (opc)
          opcAnd:  res = a & b;
          opcEor:  res = a ^ b;
          opcOrr:  res = a | b;
          opcMov:  res = b;
          default: res = wide[31:0];
        endcase
        if (opc != opcCmp) begin
          mKnown[w[15:12]] = (w[25] || mKnown[w[3:0]]) && (opc == opcMov || mKnown[w[19:16]]);
          mRegs[w[15:12]]  = res;
        end
        if (w[20] || opc == opcCmp) begin
          mFlags[3:2] = {res[31], res == 32'h0};
          if (isSub || opc == opcAdd) begin
            // Signed overflow, C is set when no borrow occurs
            ovf = isSub ? (a[31] != b[31]) && (res[31] != a[31])
                        : (a[31] == b[31]) && (res[31] != a[31]);
            mFlags[1:0] = {isSub ? !wide[32] : wide[32], ovf};
          end
        end
      end
    end
  endtask

  task automatic checkState(input string name);
    logic [31:0] val;
    for (int r = 0; r < 16; r++) begin
      if (mKnown[r]) begin
        wbRead(`REGS_BASE + 12'(r * 4), val);
        checkEqual($sformatf("%s r%0d", name, r), mRegs[r], val);
      end
    end
    wbRead(`FLAGS_ADR, val);
    checkEqual({name, " flags"}, {28'h0, mFlags}, val);
  endtask

  task automatic runAndCheck(input string name);
    runModel();
    wbWrite(`CTRL_ADR, 32'h1);
    waitHalted();
    checkState(name);
  endtask

  task automatic testReset();
    logic [31:0] val;
    wbRead(`STATUS_ADR, val);
    checkEqual("reset status", 32'h0, val);
    wbRead(12'h200, val);
    checkEqual("unmapped read", 32'h0, val);
  endtask

  task automatic testForwardChain();
    prog = {};
    prog.push_back(encode(ccAl, 1'b1, opcMov, 1'b0, 4'd0, 4'd1, 12'h05A));
    prog.push_back(encode(ccAl, 1'b1, opcMov, 1'b0, 4'd0, 4'd2, 12'h033));
    // Rm from M, Rn from W
    prog.push_back(encode(ccAl, 1'b0, opcAdd, 1'b0, 4'd1, 4'd3, 12'h002));
    // Rn from M, Rm through the write-through
    prog.push_back(encode(ccAl, 1'b0, opcSub, 1'b1, 4'd3, 4'd4, 12'h001));
    prog.push_back(encode(ccAl, 1'b0, opcAnd, 1'b0, 4'd4, 4'd5, 12'h003));
    prog.push_back(encode(ccAl, 1'b1, opcOrr, 1'b0, 4'd5, 4'd6, 12'h0F0));
    prog.push_back(encode(ccAl, 1'b0, opcEor, 1'b1, 4'd6, 4'd7, 12'h002));
    prog.push_back(encode(ccAl, 1'b0, opcAdd, 1'b0, 4'd7, 4'd8, 12'h007));
    prog.push_back(encode(ccAl, 1'b0, opcMov, 1'b0, 4'd0, 4'd9, 12'h008));
    prog.push_back(haltWord);
    loadProg();
    runAndCheck("forward chain");
  endtask

  task automatic testCondExec();
    prog = {};
    prog.push_back(encode(ccAl, 1'b1, opcMov, 1'b0, 4'd0, 4'd13, 12'h055));
    prog.push_back(encode(ccAl, 1'b1, opcMov, 1'b0, 4'd0, 4'd14, 12'h066));
    prog.push_back(encode(ccAl, 1'b1, opcMov, 1'b0, 4'd0, 4'd10, 12'h007));
    prog.push_back(encode(ccAl, 1'b1, opcMov, 1'b0, 4'd0, 4'd11, 12'h007));
    prog.push_back(encode(ccAl, 1'b0, opcCmp, 1'b0, 4'd10, 4'd0, 12'h00B));
    prog.push_back(encode(ccEq, 1'b1, opcAdd, 1'b0, 4'd10, 4'd12, 12'h001));
    prog.push_back(encode(ccNe, 1'b1, opcAdd, 1'b0, 4'd10, 4'd13, 12'h002));
    prog.push_back(encode(ccAl, 1'b1, opcCmp, 1'b0, 4'd10, 4'd0, 12'h009));
    prog.push_back(encode(ccEq, 1'b1, opcAdd, 1'b0, 4'd10, 4'd14, 12'h003));
    prog.push_back(encode(ccNe, 1'b1, opcAdd, 1'b0, 4'd10, 4'd15, 12'h004));
    prog.push_back(haltWord);
    loadProg();
    runAndCheck("conditional");
  endtask

  task automatic testRandomProg();
    logic [31:0] r;
    prog = {};
    // Defined values in every register first
    for (int i = 0; i < 16; i++) begin
      r = lcgNext();
      prog.push_back(encode(ccAl, 1'b1, opcMov, 1'b0, 4'd0, 4'(i), {4'h0, r[31:24]}));
    end
    for (int i = 0; i < 24; i++) begin
      r = lcgNext();
      prog.push_back(encode(condList[r[31:30]], r[29], opcList[r[28:26] % 7], r[25],
                            r[23:20], r[19:16], r[29] ? {4'h0, r[15:8]} : {8'h0, r[11:8]}));
    end
    prog.push_back(haltWord);
    loadProg();
    runAndCheck("random program");
  endtask

  task automatic testRestart();
    logic [31:0] val;
    runModel();
    wbWrite(`CTRL_ADR, 32'h1);
    // Overwrite the program head and the first random instruction, still ahead of the PC
    wbWrite(12'h000, haltWord);
    wbWrite(12'h040, haltWord);
    wbRead(`STATUS_ADR, val);
    checkEqual("running during imem write", 32'h1, val);
    waitHalted();
    checkState("imem write while running");
    runAndCheck("restart");
  endtask

  initial begin
    rstN        = 1'b0;
    wbReq       = '0;
    checks      = 0;
    mismatches  = 0;
    otherErrors = 0;
    lcgState    = 32'd8710;
    foreach (mKnown[r]) mKnown[r] = 1'b0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    testReset();
    testForwardChain();
    testCondExec();
    testRandomProg();
    testRestart();
    finishRun();
  end

endmodule
